//--- common/mem_mapper_params.svh
`ifndef MEM_MAPPER_PARAMS_SVH
`define MEM_MAPPER_PARAMS_SVH

// host side
`define MM_ADDR_W 30
`define MM_DATA_W 32

// dram geometry
`define MM_ROW_W 16
`define MM_COL_W 10
`define MM_BANKS 16  // {bank_group, bank}

// entry index widths
`define MM_RD_ENTRIES_LOG 4
`define MM_WR_ENTRIES_LOG 4

// index port, wide enough for either counter
`define MM_IDX_W 4

`endif

//--- common/mem_mapper_pkg.sv
`default_nettype none

`include "mem_mapper_params.svh"

package mem_mapper_pkg;

	// host word address in mapping-scheme order, msb first
	typedef struct packed {
		logic [`MM_ROW_W-1:0] row;      // adr[29:14]
		logic [1:0]           bank;     // adr[13:12]
		logic [5:0]           col_hi;   // adr[11:6]
		logic [1:0]           bank_group; // adr[5:4]
		logic [3:0]           col_lo;   // adr[3:0]
	} phys_addr_fields_t;

	// decoder writes flat, the mapper reads fields
	typedef union packed {
		logic [`MM_ADDR_W-1:0] flat;
		phys_addr_fields_t     fields;
	} phys_addr_u;

endpackage

`default_nettype wire

//--- rtl/wb_req_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_mapper_params.svh"

module wb_req_decoder (
	input  wire                       clk,
	input  wire                       rst_n,
	// wishbone classic slave
	input  wire                       wb_cyc_i,
	input  wire                       wb_stb_i,
	input  wire                       wb_we_i,
	input  wire [`MM_ADDR_W-1:0]      wb_adr_i,
	input  wire [`MM_DATA_W-1:0]      wb_dat_i,
	output logic                      wb_ack_o,
	output logic [`MM_DATA_W-1:0]     wb_dat_o,
	// completion from issue stage
	input  wire                       done_i,
	input  wire [`MM_IDX_W-1:0]       done_index_i,
	// captured request
	output logic                      req_valid_o,
	output logic                      req_we_o,
	output mem_mapper_pkg::phys_addr_u req_addr_o,
	output logic [`MM_DATA_W-1:0]     req_data_o
);

	localparam int DATA_W = `MM_DATA_W;

	typedef enum logic {
		ST_IDLE,
		ST_PENDING
	} dec_state_t;

	dec_state_t state;

	logic cycle_start;

	assign cycle_start = wb_cyc_i & wb_stb_i;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state       <= ST_IDLE;
			req_valid_o <= 1'b0;
		end else begin
			req_valid_o <= 1'b0; // single-cycle pulse
			case (state)
				ST_IDLE: begin
					if (cycle_start) begin
						req_valid_o <= 1'b1;
						state       <= ST_PENDING;
					end
				end
				ST_PENDING: begin
					// bus is ignored here, including the strobe seen during ack
					if (done_i) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request payload, taken only when a new cycle is accepted
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cycle_start) begin
			req_we_o        <= wb_we_i;
			req_addr_o.flat <= wb_adr_i;
			req_data_o      <= wb_dat_i;
		end
	end

	// ack follows the registered done flag directly
	assign wb_ack_o = (state == ST_PENDING) & done_i;
	assign wb_dat_o = DATA_W'(done_index_i); // zero-extended entry index

endmodule

`default_nettype wire

//--- mapper/addr_scheme.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_mapper_params.svh"

module addr_scheme (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        req_valid_i,
	input  wire                        req_we_i,
	input  wire mem_mapper_pkg::phys_addr_u req_addr_i,
	input  wire [`MM_DATA_W-1:0]       req_data_i,
	output logic                       map_valid_o,
	output logic                       map_we_o,
	output logic [`MM_ROW_W-1:0]       map_row_o,
	output logic [`MM_COL_W-1:0]       map_col_o,
	output logic [$clog2(`MM_BANKS)-1:0] map_bank_o,
	output logic [`MM_DATA_W-1:0]      map_data_o
);

	import mem_mapper_pkg::*;

	phys_addr_fields_t fld;
	logic [1:0]        hashed_bank;
	logic [1:0]        hashed_group;

	assign fld = req_addr_i.fields;

	// xor with low row bits spreads row-sequential traffic over banks
	assign hashed_bank  = fld.bank ^ fld.row[1:0];       // adr[15:14]
	assign hashed_group = fld.bank_group ^ fld.row[3:2]; // adr[17:16]

	always_ff @(posedge clk) begin
		if (rst_n) begin
			map_valid_o <= 1'b0;
		end else begin
			map_valid_o <= req_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			map_we_o   <= req_we_i;
			map_row_o  <= fld.row;
			map_col_o  <= {fld.col_hi, fld.col_lo};
			map_bank_o <= {hashed_group, hashed_bank}; // group*4 + bank
			map_data_o <= req_data_i;
		end
	end

endmodule

`default_nettype wire

//--- mapper/bank_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_mapper_params.svh"

module bank_dispatcher (
	input  wire                          clk,
	input  wire                          rst_n,
	// mapped request
	input  wire                          map_valid_i,
	input  wire                          map_we_i,
	input  wire [`MM_ROW_W-1:0]          map_row_i,
	input  wire [`MM_COL_W-1:0]          map_col_i,
	input  wire [$clog2(`MM_BANKS)-1:0]  map_bank_i,
	input  wire [`MM_DATA_W-1:0]         map_data_i,
	// overflow stopper and bank status
	input  wire                          stop_reading_i,
	input  wire                          stop_writing_i,
	input  wire [`MM_BANKS-1:0]          bank_busy_i,
	// issue towards the result stage
	output logic                         issue_o,
	output logic                         issue_we_o,
	output logic [$clog2(`MM_BANKS)-1:0] issue_bank_o,
	output logic [`MM_ROW_W-1:0]         issue_row_o,
	output logic [`MM_COL_W-1:0]         issue_col_o,
	output logic [`MM_DATA_W-1:0]        issue_data_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RESET
	} disp_state_t;

	disp_state_t state;
	disp_state_t next_state;

	// stalled request
	logic                         wait_we;
	logic [$clog2(`MM_BANKS)-1:0] wait_bank;
	logic [`MM_ROW_W-1:0]         wait_row;
	logic [`MM_COL_W-1:0]         wait_col;
	logic [`MM_DATA_W-1:0]        wait_data;

	logic cand_valid;
	logic stop_hit;
	logic can_issue;
	logic save_req;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= ST_RESET;
		end else begin
			state <= next_state;
		end
	end

	// candidate is either the waiting request or the fresh one
	always_comb begin
		if (state == ST_WAIT) begin
			cand_valid   = 1'b1;
			issue_we_o   = wait_we;
			issue_bank_o = wait_bank;
			issue_row_o  = wait_row;
			issue_col_o  = wait_col;
			issue_data_o = wait_data;
		end else begin
			cand_valid   = map_valid_i & (state == ST_IDLE);
			issue_we_o   = map_we_i;
			issue_bank_o = map_bank_i;
			issue_row_o  = map_row_i;
			issue_col_o  = map_col_i;
			issue_data_o = map_data_i;
		end
	end

	assign stop_hit  = issue_we_o ? stop_writing_i : stop_reading_i;
	assign can_issue = ~stop_hit & ~bank_busy_i[issue_bank_o];
	assign issue_o   = cand_valid & can_issue;
	assign save_req  = (state == ST_IDLE) & map_valid_i & ~can_issue;

	always_comb begin
		next_state = state;
		case (state)
			ST_RESET: next_state = ST_IDLE;
			ST_IDLE:  if (save_req) next_state = ST_WAIT;
			ST_WAIT:  if (can_issue) next_state = ST_IDLE; // retried every cycle
			default:  next_state = ST_IDLE;
		endcase
	end

	// write data stays here with the rest of the request
	always_ff @(posedge clk) begin
		if (save_req) begin
			wait_we   <= map_we_i;
			wait_bank <= map_bank_i;
			wait_row  <= map_row_i;
			wait_col  <= map_col_i;
			wait_data <= map_data_i;
		end
	end

endmodule

`default_nettype wire

//--- mapper/issue_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_mapper_params.svh"

module issue_result (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          issue_i,
	input  wire                          issue_we_i,
	input  wire [$clog2(`MM_BANKS)-1:0]  issue_bank_i,
	input  wire [`MM_ROW_W-1:0]          issue_row_i,
	input  wire [`MM_COL_W-1:0]          issue_col_i,
	input  wire [`MM_DATA_W-1:0]         issue_data_i,
	// bank side
	output logic [`MM_BANKS-1:0]         bank_valid_o,
	output logic                         bank_we_o,
	output logic [`MM_ROW_W-1:0]         bank_row_o,
	output logic [`MM_COL_W-1:0]         bank_col_o,
	output logic [`MM_DATA_W-1:0]        bank_data_o,
	output logic [`MM_IDX_W-1:0]         bank_index_o,
	// to the overflow stopper
	output logic                         issue_valid_o,
	// back to the decoder
	output logic                         done_o,
	output logic [`MM_IDX_W-1:0]         done_index_o
);

	localparam int IDX_W = `MM_IDX_W;

	logic [`MM_RD_ENTRIES_LOG-1:0] rd_cnt;
	logic [`MM_WR_ENTRIES_LOG-1:0] wr_cnt;
	logic [IDX_W-1:0]              cur_index;
	logic [`MM_BANKS-1:0]          bank_onehot;

	assign cur_index   = issue_we_i ? IDX_W'(wr_cnt) : IDX_W'(rd_cnt);
	assign bank_onehot = issue_i ? (`MM_BANKS'(1) << issue_bank_i) : '0;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			rd_cnt        <= '0;
			wr_cnt        <= '0;
			bank_valid_o  <= '0;
			issue_valid_o <= 1'b0;
			done_o        <= 1'b0;
		end else begin
			// each counter wraps and moves only on its own kind
			if (issue_i && issue_we_i) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
			if (issue_i && !issue_we_i) begin
				rd_cnt <= rd_cnt + 1'b1;
			end
			bank_valid_o  <= bank_onehot;
			issue_valid_o <= issue_i;
			done_o        <= issue_i;
		end
	end

	// payload only moves on an issue
	always_ff @(posedge clk) begin
		if (issue_i) begin
			bank_we_o    <= issue_we_i;
			bank_row_o   <= issue_row_i;
			bank_col_o   <= issue_col_i;
			bank_data_o  <= issue_data_i;
			bank_index_o <= cur_index;
			done_index_o <= cur_index;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_mapper_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_mapper_params.svh"

module mem_mapper_top (
	input  wire                          clk,
	input  wire                          rst_n,
	// wishbone classic slave
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wire [`MM_ADDR_W-1:0]         wb_adr_i,
	input  wire [`MM_DATA_W-1:0]         wb_dat_i,
	output logic                         wb_ack_o,
	output logic [`MM_DATA_W-1:0]        wb_dat_o,
	// overflow stopper
	input  wire                          stop_reading_i,
	input  wire                          stop_writing_i,
	output logic                         issue_valid_o,
	// banks
	input  wire [`MM_BANKS-1:0]          bank_busy_i,
	output logic [`MM_BANKS-1:0]         bank_valid_o,
	output logic                         bank_we_o,
	output logic [`MM_ROW_W-1:0]         bank_row_o,
	output logic [`MM_COL_W-1:0]         bank_col_o,
	output logic [`MM_DATA_W-1:0]        bank_data_o,
	output logic [`MM_IDX_W-1:0]         bank_index_o
);

	import mem_mapper_pkg::*;

	logic                         req_valid, req_we;
	phys_addr_u                   req_addr;
	logic [`MM_DATA_W-1:0]        req_data;

	logic                         map_valid, map_we;
	logic [`MM_ROW_W-1:0]         map_row;
	logic [`MM_COL_W-1:0]         map_col;
	logic [$clog2(`MM_BANKS)-1:0] map_bank;
	logic [`MM_DATA_W-1:0]        map_data;

	logic                         issue, issue_we;
	logic [$clog2(`MM_BANKS)-1:0] issue_bank;
	logic [`MM_ROW_W-1:0]         issue_row;
	logic [`MM_COL_W-1:0]         issue_col;
	logic [`MM_DATA_W-1:0]        issue_data;

	logic                         done_pulse;
	logic [`MM_IDX_W-1:0]         done_index;

	wb_req_decoder u_decoder (
		.clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
		.wb_ack_o, .wb_dat_o, .done_i(done_pulse), .done_index_i(done_index),
		.req_valid_o(req_valid), .req_we_o(req_we), .req_addr_o(req_addr),
		.req_data_o(req_data)
	);

	addr_scheme u_scheme (
		.clk, .rst_n, .req_valid_i(req_valid), .req_we_i(req_we),
		.req_addr_i(req_addr), .req_data_i(req_data),
		.map_valid_o(map_valid), .map_we_o(map_we), .map_row_o(map_row),
		.map_col_o(map_col), .map_bank_o(map_bank), .map_data_o(map_data)
	);

	bank_dispatcher u_dispatch (
		.clk, .rst_n, .map_valid_i(map_valid), .map_we_i(map_we),
		.map_row_i(map_row), .map_col_i(map_col), .map_bank_i(map_bank),
		.map_data_i(map_data), .stop_reading_i, .stop_writing_i, .bank_busy_i,
		.issue_o(issue), .issue_we_o(issue_we), .issue_bank_o(issue_bank),
		.issue_row_o(issue_row), .issue_col_o(issue_col), .issue_data_o(issue_data)
	);

	issue_result u_result (
		.clk, .rst_n, .issue_i(issue), .issue_we_i(issue_we),
		.issue_bank_i(issue_bank), .issue_row_i(issue_row), .issue_col_i(issue_col),
		.issue_data_i(issue_data), .bank_valid_o, .bank_we_o, .bank_row_o,
		.bank_col_o, .bank_data_o, .bank_index_o, .issue_valid_o,
		.done_o(done_pulse), .done_index_o(done_index)
	);

endmodule

`default_nettype wire

//--- tests/tb_mem_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_mapper_params.svh"

module tb_mem_mapper;

	localparam int    MAX_TESTS  = 64;
	localparam int    MAX_GAP    = 4;
	localparam int    RST_CYCLES = 8;
	localparam [31:0] RAND_SEED  = 32'h72b6b654;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic                  wb_we_i;
	logic [`MM_ADDR_W-1:0] wb_adr_i;
	logic [`MM_DATA_W-1:0] wb_dat_i;
	logic                  wb_ack_o;
	logic [`MM_DATA_W-1:0] wb_dat_o;
	logic                  stop_reading_i;
	logic                  stop_writing_i;
	logic                  issue_valid_o;
	logic [`MM_BANKS-1:0]  bank_busy_i;
	logic [`MM_BANKS-1:0]  bank_valid_o;
	logic                  bank_we_o;
	logic [`MM_ROW_W-1:0]  bank_row_o;
	logic [`MM_COL_W-1:0]  bank_col_o;
	logic [`MM_DATA_W-1:0] bank_data_o;
	logic [`MM_IDX_W-1:0]  bank_index_o;

	// one entry per stimulus line
	logic [8*16-1:0]       t_name  [MAX_TESTS];
	logic                  t_we    [MAX_TESTS];
	logic [`MM_ADDR_W-1:0] t_adr   [MAX_TESTS];
	logic [`MM_DATA_W-1:0] t_dat   [MAX_TESTS];
	logic                  t_srd   [MAX_TESTS];
	logic                  t_swr   [MAX_TESTS];
	logic [`MM_BANKS-1:0]  t_busy  [MAX_TESTS];
	int                    t_stall [MAX_TESTS];
	int                    t_bank  [MAX_TESTS];
	logic [`MM_ROW_W-1:0]  t_row   [MAX_TESTS];
	logic [`MM_COL_W-1:0]  t_col   [MAX_TESTS];
	int                    t_idx   [MAX_TESTS];

	int n_tests;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	int test_errors;
	int total_errors;
	int tests_failed;

	mem_mapper_top dut0 (
		.clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
		.wb_ack_o, .wb_dat_o, .stop_reading_i, .stop_writing_i, .issue_valid_o,
		.bank_busy_i, .bank_valid_o, .bank_we_o, .bank_row_o, .bank_col_o,
		.bank_data_o, .bank_index_o
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped acknowledging", cycle_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic load_stimulus(output int count);
		int               fd;
		int               got;
		logic [8*160-1:0] line;
		logic [8*16-1:0]  name;
		logic [8*4-1:0]   op;
		logic [31:0]      adr, dat, busy, row, col;
		int               srd, swr, stall, bank, idx;
		count = 0;
		fd = $fopen("tests/mem_mapper_stimulus.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0 && count < MAX_TESTS) begin
				got = $sscanf(line, "%s %s %h %h %d %d %h %d %d %h %h %d",
					name, op, adr, dat, srd, swr, busy, stall, bank, row, col, idx);
				if (got == 12) begin // header lines never give all columns
					t_name[count]  = name;
					t_we[count]    = (op == "wr");
					t_adr[count]   = adr;
					t_dat[count]   = dat;
					t_srd[count]   = srd[0];
					t_swr[count]   = swr[0];
					t_busy[count]  = busy;
					t_stall[count] = stall;
					t_bank[count]  = bank;
					t_row[count]   = row;
					t_col[count]   = col;
					t_idx[count]   = idx;
					count++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic clear_backpressure();
		stop_reading_i = 1'b0;
		stop_writing_i = 1'b0;
		bank_busy_i    = '0;
	endtask

	task automatic expect_value(input int i, input string what,
			input logic [31:0] exp_v, input logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("Fail %0s: %0s expected 0x%0h actual 0x%0h", t_name[i], what, exp_v, act_v);
			test_errors++;
		end
	endtask

	// one wishbone classic cycle, back-pressure driven with it
	task automatic run_request(input int i);
		int                   cycles;
		bit                   acked;
		logic [`MM_BANKS-1:0] onehot;
		cycles = 0;
		acked = 1'b0;
		onehot = '0;
		onehot[t_bank[i]] = 1'b1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = t_we[i];
		wb_adr_i = t_adr[i];
		wb_dat_i = t_dat[i];
		stop_reading_i = t_srd[i];
		stop_writing_i = t_swr[i];
		bank_busy_i    = t_busy[i];
		while (!acked) begin
			@(posedge clk);
			cycles++;
			#1;
			// first issue attempt is in cycle 2, so this leaves t_stall failed attempts
			if (t_stall[i] > 0 && cycles == t_stall[i] + 2) begin
				clear_backpressure();
			end
			@(negedge clk);
			if (wb_ack_o) begin
				acked = 1'b1;
			end else begin
				assert (bank_valid_o == '0) else begin
					$display("%0s: bank request seen %0d cycles in, before any acknowledge",
						t_name[i], cycles);
					test_errors++;
				end
			end
		end
		expect_value(i, "latency", 3 + t_stall[i], cycles);
		expect_value(i, "bank_valid_o", onehot, bank_valid_o);
		expect_value(i, "bank_row_o", t_row[i], bank_row_o);
		expect_value(i, "bank_col_o", t_col[i], bank_col_o);
		expect_value(i, "bank_we_o", t_we[i], bank_we_o);
		expect_value(i, "wb_dat_o", t_idx[i], wb_dat_o); // index, zero-extended
		expect_value(i, "bank_index_o", t_idx[i], bank_index_o);
		expect_value(i, "issue_valid_o", 1, issue_valid_o);
		if (t_we[i]) begin
			expect_value(i, "bank_data_o", t_dat[i], bank_data_o);
		end
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		clear_backpressure();
		@(negedge clk);
		assert (!wb_ack_o && bank_valid_o == '0) else begin
			$display("%0s: acknowledge or bank request lasted more than one cycle", t_name[i]);
			test_errors++;
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		int i;
		int gap;
		int seed_out;
		rst_n    = 1'b1; // reset is active high
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		clear_backpressure();
		seed_out = $urandom(RAND_SEED);
		total_errors = 0;
		tests_failed = 0;
		load_stimulus(n_tests);
		if (n_tests == 0) begin
			$display("no request could be read from tests/mem_mapper_stimulus.txt");
			$display("Simulation FAILED");
		end else begin
			cycle_limit = RST_CYCLES;
			for (i = 0; i < n_tests; i++) begin
				cycle_limit += t_stall[i] + MAX_GAP + 10;
			end
			repeat (RST_CYCLES) @(posedge clk);
			#1;
			rst_n = 1'b0;
			@(negedge clk);
			assert (!wb_ack_o && bank_valid_o == '0 && !issue_valid_o) else begin
				$display("outputs were not idle after reset");
				total_errors++;
			end
			@(posedge clk);
			#1;
			for (i = 0; i < n_tests; i++) begin
				gap = $urandom % (MAX_GAP + 1);
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
				test_errors = 0;
				run_request(i);
				if (test_errors == 0) begin
					$display("test %0s: ok, index %0d", t_name[i], t_idx[i]);
				end else begin
					$display("test %0s: %0d check(s) wrong", t_name[i], test_errors);
					tests_failed++;
				end
				total_errors += test_errors;
			end
			$display("summary: %0d tests, %0d failed, %0d errors",
				n_tests, tests_failed, total_errors);
			if (total_errors == 0) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_mapper.f
+incdir+common
common/mem_mapper_pkg.sv
rtl/wb_req_decoder.sv
mapper/addr_scheme.sv
mapper/bank_dispatcher.sv
mapper/issue_result.sv
rtl/mem_mapper_top.sv
tests/tb_mem_mapper.sv

//--- Bender.yml
package:
  name: mem_mapper

sources:
  - include_dirs:
      - common
    files:
      - common/mem_mapper_pkg.sv
      - rtl/wb_req_decoder.sv
      - mapper/addr_scheme.sv
      - mapper/bank_dispatcher.sv
      - mapper/issue_result.sv
      - rtl/mem_mapper_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_mem_mapper.sv

//--- tests/mem_mapper_stimulus.txt
# name op adr data stop_rd stop_wr busy stall | exp_bank exp_row exp_col exp_index
# adr data busy row col are hex, stop flags stall bank index are decimal
rd_basic      rd 00001234 00000000 0 0 0000 0 13 0000 084 0
rd_row        rd 048c2fcf 00000000 0 0 0000 0  2 1230 3ff 1
wr_basic      wr 2af3456a deadbeef 0 0 0000 0  5 abcd 15a 0
wr_second     wr 0000a010 01234567 0 0 0000 0  4 0002 000 1
rd_after_wr   rd 00003041 00000000 0 0 0000 0  3 0000 011 2

xor_row0      rd 00000085 00000000 0 0 0000 0  0 0000 025 3
xor_row1      rd 00004085 00000000 0 0 0000 0  1 0001 025 4
xor_row4      rd 00010085 00000000 0 0 0000 0  4 0004 025 5
xor_rowf      rd 0003c085 00000000 0 0 0000 0 15 000f 025 6

stop_rd       rd 00401000 00000000 1 0 0000 4  1 0100 000 7
stop_wr       wr 004020d7 cafef00d 0 1 0000 3  6 0100 037 2
stop_wr_pass  rd 00000022 00000000 0 1 0000 0  8 0000 002 8
stop_rd_pass  wr 00001010 5a5a5a5a 1 0 0000 0  5 0000 000 3

busy_hit      rd 00001234 00000000 0 0 2000 2 13 0000 084 9
busy_miss     rd 048c2fcf 00000000 0 0 2000 0  2 1230 3ff 10
busy_wr_hit   wr 2af3456a 11111111 0 0 0020 5  5 abcd 15a 4
busy_wr_miss  wr 0000a010 22222222 0 0 ffef 0  4 0002 000 5

fill_11       rd 00003041 00000000 0 0 0000 0  3 0000 011 11
fill_12       rd 00000085 00000000 0 0 0000 0  0 0000 025 12
fill_13       rd 00004085 00000000 0 0 0000 0  1 0001 025 13
fill_14       rd 00010085 00000000 0 0 0000 0  4 0004 025 14
fill_15       rd 0003c085 00000000 0 0 0000 0 15 000f 025 15
rd_wrap       rd 00001234 00000000 0 0 0000 0 13 0000 084 0
wr_after_wrap wr 00000022 33333333 0 0 0000 0  8 0000 002 6
rd_wrap_next  rd 048c2fcf 00000000 0 0 0000 0  2 1230 3ff 1
stop_rd_long  rd 00401000 00000000 1 0 0000 7  1 0100 000 2
